// File: dcache_pkg.sv
`default_nettype none

package dcache_pkg;

	////////////////////////////////////////////////////////////
	// Sizes and address fields
	////////////////////////////////////////////////////////////
	localparam int ADDR_W = 32;
	localparam int DATA_W = 32;
	localparam int STRB_W = DATA_W / 8;
	localparam int BYTE_LSB = 2;
	// 64 words in 8 lines of 8 words
	localparam int LG_WORDS = 6;
	localparam int LG_LINE = 3;
	localparam int LG_LINES = LG_WORDS - LG_LINE;
	localparam int TAG_W = ADDR_W - LG_WORDS - BYTE_LSB;
	localparam int NAUX = 5;
	localparam int LINE_ARLEN = (1 << LG_LINE) - 1;
	localparam int UNCACHED_BIT = 31;
	localparam int RESP_ERR_BIT = 1;

	// Bit 0 marks a write, bits 2..1 give the size
	typedef enum logic [2:0] {
		OP_LW = 3'b000,
		OP_SW = 3'b001,
		OP_LH = 3'b100,
		OP_SH = 3'b101,
		OP_LB = 3'b110,
		OP_SB = 3'b111
	} mem_op_t;

	typedef enum logic [2:0] {
		REQ_NONE,
		REQ_CREAD,
		REQ_UREAD,
		REQ_WRITE,
		REQ_BAD
	} req_kind_t;

	typedef enum logic [1:0] {
		BUS_IDLE,
		BUS_WRITE,
		BUS_READ_SINGLE,
		BUS_READ_LINE
	} bus_state_t;

	////////////////////////////////////////////////////////////
	// Byte-lane helpers
	////////////////////////////////////////////////////////////
	function automatic logic [STRB_W-1:0] lane_strb(mem_op_t op, logic [BYTE_LSB-1:0] off);
		case (op[2:1])
		2'b10:   return 4'b0011 << off;
		2'b11:   return 4'b0001 << off;
		default: return 4'b1111;
		endcase
	endfunction

	function automatic logic [DATA_W-1:0] lane_data(mem_op_t op, logic [DATA_W-1:0] d,
			logic [BYTE_LSB-1:0] off);
		case (op[2:1])
		2'b10:   return {16'h0, d[15:0]} << {off, 3'b000};
		2'b11:   return {24'h0, d[7:0]} << {off, 3'b000};
		default: return d;
		endcase
	endfunction

	// AXI size code, bytes per beat as a power of two
	function automatic logic [2:0] op_axsize(mem_op_t op);
		case (op[2:1])
		2'b10:   return 3'd1;
		2'b11:   return 3'd0;
		default: return 3'd2;
		endcase
	endfunction

	function automatic logic [DATA_W-1:0] lane_extract(mem_op_t op, logic [DATA_W-1:0] w,
			logic [BYTE_LSB-1:0] off);
		logic [DATA_W-1:0] shifted;

		shifted = w >> {off, 3'b000};
		case (op[2:1])
		2'b10:   return {16'h0, shifted[15:0]};
		2'b11:   return {24'h0, shifted[7:0]};
		default: return shifted;
		endcase
	endfunction

endpackage

`default_nettype wire

// File: dcache_request.sv
`timescale 1ns/10ps
`default_nettype none

module dcache_request (
	input	wire				S_AXI_ACLK,
	input	wire				S_AXI_ARESETN,
	input	wire				i_pipe_stb,
	input	wire dcache_pkg::mem_op_t	i_op,
	input	wire [dcache_pkg::ADDR_W-1:0]	i_addr,
	input	wire [dcache_pkg::DATA_W-1:0]	i_data,
	input	wire [dcache_pkg::NAUX-1:0]	i_oreg,
	input	wire				i_busy,
	output	dcache_pkg::req_kind_t		o_kind,
	output	dcache_pkg::mem_op_t		o_op,
	output	logic [dcache_pkg::ADDR_W-1:0]	o_addr,
	output	logic [dcache_pkg::DATA_W-1:0]	o_data,
	output	logic [dcache_pkg::NAUX-1:0]	o_wreg
);

	logic	accept;
	logic	misaligned;

	assign accept = i_pipe_stb && !i_busy;

	// Bytes never misalign, a half only at the last lane
	always_comb
	begin
		case (i_op[2:1])
		2'b10:   misaligned = (i_addr[dcache_pkg::BYTE_LSB-1:0] == 2'd3);
		2'b11:   misaligned = 1'b0;
		default: misaligned = (i_addr[dcache_pkg::BYTE_LSB-1:0] != 2'd0);
		endcase
	end

	// One-cycle classification pulse
	always_ff @(posedge S_AXI_ACLK)
	begin
		if (!S_AXI_ARESETN)
			o_kind <= dcache_pkg::REQ_NONE;
		else if (!accept)
			o_kind <= dcache_pkg::REQ_NONE;
		else if (misaligned)
			o_kind <= dcache_pkg::REQ_BAD;
		else if (i_op[0])
			o_kind <= dcache_pkg::REQ_WRITE;
		else if (i_addr[dcache_pkg::UNCACHED_BIT])
			o_kind <= dcache_pkg::REQ_UREAD;
		else
			o_kind <= dcache_pkg::REQ_CREAD;
	end

	// Request fields held until the next acceptance
	always_ff @(posedge S_AXI_ACLK)
	begin
		if (accept)
		begin
			o_op <= i_op;
			o_addr <= i_addr;
			o_data <= i_data;
			o_wreg <= i_oreg;
		end
	end

endmodule

`default_nettype wire

// File: dcache_lookup.sv
`timescale 1ns/10ps
`default_nettype none

module dcache_lookup (
	input	wire				S_AXI_ACLK,
	input	wire				S_AXI_ARESETN,
	input	wire				i_clear,
	input	wire dcache_pkg::req_kind_t	i_kind,
	input	wire dcache_pkg::mem_op_t	i_op,
	input	wire [dcache_pkg::ADDR_W-1:0]	i_addr,
	input	wire [dcache_pkg::DATA_W-1:0]	i_data,
	input	wire				i_fill_beat,
	input	wire [dcache_pkg::DATA_W-1:0]	i_fill_word,
	input	wire				i_fill_done,
	input	wire				i_fill_err,
	input	wire				i_wr_done,
	output	logic				o_hit_valid,
	output	logic [dcache_pkg::DATA_W-1:0]	o_hit_word,
	output	logic				o_fill_req,
	output	logic [dcache_pkg::ADDR_W-1:0]	o_fill_addr
);

	logic	[(1<<dcache_pkg::LG_LINES)-1:0]	line_valid;
	logic	[dcache_pkg::TAG_W-1:0]		line_tag [0:(1<<dcache_pkg::LG_LINES)-1];
	logic	[dcache_pkg::DATA_W-1:0]	mem [0:(1<<dcache_pkg::LG_WORDS)-1];

	logic	[dcache_pkg::LG_WORDS-1:0]	req_word;
	logic	[dcache_pkg::LG_LINES-1:0]	req_line;
	logic	[dcache_pkg::TAG_W-1:0]		req_tag;
	logic					line_present;

	logic				rd_chk;
	logic				rd_valid;
	logic				recheck;
	logic	[dcache_pkg::TAG_W-1:0]	rd_tag;
	logic	[dcache_pkg::DATA_W-1:0]	rd_word;
	logic				hit_now;
	logic	[dcache_pkg::LG_LINE-1:0]	fill_cnt;

	logic	[dcache_pkg::LG_WORDS-1:0]	wr_idx;
	logic	[dcache_pkg::DATA_W-1:0]	wr_val;
	logic	[dcache_pkg::STRB_W-1:0]	wr_strb;

	////////////////////////////////////////////////////////////
	// Address fields of the held request
	////////////////////////////////////////////////////////////
	assign req_word = i_addr[dcache_pkg::BYTE_LSB +: dcache_pkg::LG_WORDS];
	assign req_line = req_word[dcache_pkg::LG_WORDS-1 -: dcache_pkg::LG_LINES];
	assign req_tag = i_addr[dcache_pkg::ADDR_W-1 -: dcache_pkg::TAG_W];

	// Used by write-through to decide whether the copy is live
	assign line_present = line_valid[req_line] && (line_tag[req_line] == req_tag);

	assign hit_now = rd_valid && (rd_tag == req_tag);

	////////////////////////////////////////////////////////////
	// Lookup control and valid bits
	////////////////////////////////////////////////////////////
	always_ff @(posedge S_AXI_ACLK)
	begin
		if (!S_AXI_ARESETN)
		begin
			rd_chk <= 1'b0;
			recheck <= 1'b0;
			o_hit_valid <= 1'b0;
			o_fill_req <= 1'b0;
			fill_cnt <= '0;
			line_valid <= '0;
		end
		else
		begin
			// A finished fill runs the read stage once more
			rd_chk <= (i_kind == dcache_pkg::REQ_CREAD) || recheck;
			recheck <= i_fill_done;
			o_hit_valid <= rd_chk && hit_now;
			o_fill_req <= rd_chk && !hit_now;

			if (o_fill_req)
				fill_cnt <= '0;
			else if (i_fill_beat)
				fill_cnt <= fill_cnt + 1'b1;

			// Line stays invalid while its words are replaced
			if (rd_chk && !hit_now)
				line_valid[req_line] <= 1'b0;
			if (i_fill_done)
				line_valid[req_line] <= 1'b1;
			if (i_fill_err)
				line_valid[req_line] <= 1'b0;
			if (i_clear)
				line_valid <= '0;
		end
	end

	// Read stage, then compare stage
	always_ff @(posedge S_AXI_ACLK)
	begin
		rd_valid <= line_valid[req_line];
		rd_tag <= line_tag[req_line];
		rd_word <= mem[req_word];
		o_hit_word <= rd_word;
		o_fill_addr <= {req_tag, req_line, {(dcache_pkg::LG_LINE+dcache_pkg::BYTE_LSB){1'b0}}};
		if (rd_chk && !hit_now)
			line_tag[req_line] <= req_tag;
	end

	////////////////////////////////////////////////////////////
	// Data store writes from fill beats or write-through
	////////////////////////////////////////////////////////////
	always_comb
	begin
		if (i_fill_beat)
		begin
			wr_idx = {req_line, fill_cnt};
			wr_val = i_fill_word;
			wr_strb = '1;
		end
		else
		begin
			wr_idx = req_word;
			wr_val = dcache_pkg::lane_data(i_op, i_data, i_addr[dcache_pkg::BYTE_LSB-1:0]);
			if (i_wr_done && line_present)
				wr_strb = dcache_pkg::lane_strb(i_op, i_addr[dcache_pkg::BYTE_LSB-1:0]);
			else
				wr_strb = '0;
		end
	end

	always_ff @(posedge S_AXI_ACLK)
	begin
		for (int k = 0; k < dcache_pkg::STRB_W; k++)
		begin
			if (wr_strb[k])
				mem[wr_idx][8*k +: 8] <= wr_val[8*k +: 8];
		end
	end

endmodule

`default_nettype wire

// File: dcache_bus_master.sv
`timescale 1ns/10ps
`default_nettype none

module dcache_bus_master (
	input	wire				S_AXI_ACLK,
	input	wire				S_AXI_ARESETN,
	input	wire dcache_pkg::req_kind_t	i_kind,
	input	wire dcache_pkg::mem_op_t	i_op,
	input	wire [dcache_pkg::ADDR_W-1:0]	i_addr,
	input	wire [dcache_pkg::DATA_W-1:0]	i_data,
	input	wire				i_fill_req,
	input	wire [dcache_pkg::ADDR_W-1:0]	i_fill_addr,
	input	wire				M_AXI_AWREADY,
	input	wire				M_AXI_WREADY,
	input	wire				M_AXI_BVALID,
	input	wire [1:0]			M_AXI_BRESP,
	input	wire				M_AXI_ARREADY,
	input	wire				M_AXI_RVALID,
	input	wire [dcache_pkg::DATA_W-1:0]	M_AXI_RDATA,
	input	wire				M_AXI_RLAST,
	input	wire [1:0]			M_AXI_RRESP,
	output	logic				M_AXI_AWVALID,
	output	logic [dcache_pkg::ADDR_W-1:0]	M_AXI_AWADDR,
	output	logic [2:0]			M_AXI_AWSIZE,
	output	logic				M_AXI_WVALID,
	output	logic [dcache_pkg::DATA_W-1:0]	M_AXI_WDATA,
	output	logic [dcache_pkg::STRB_W-1:0]	M_AXI_WSTRB,
	output	logic				M_AXI_ARVALID,
	output	logic [dcache_pkg::ADDR_W-1:0]	M_AXI_ARADDR,
	output	logic [7:0]			M_AXI_ARLEN,
	output	logic [2:0]			M_AXI_ARSIZE,
	output	logic				o_fill_beat,
	output	logic [dcache_pkg::DATA_W-1:0]	o_fill_word,
	output	logic				o_fill_done,
	output	logic				o_fill_err,
	output	logic				o_bus_valid,
	output	logic [dcache_pkg::DATA_W-1:0]	o_bus_word,
	output	logic				o_bus_err,
	output	logic				o_wr_done
);

	dcache_pkg::bus_state_t		state;
	logic				line_err;
	logic				r_err;
	logic				b_err;
	logic	[dcache_pkg::DATA_W-1:0]	r_data;

	assign r_err = M_AXI_RRESP[dcache_pkg::RESP_ERR_BIT];
	assign b_err = M_AXI_BRESP[dcache_pkg::RESP_ERR_BIT];

	// One R register feeds both the fill path and single reads
	assign o_fill_word = r_data;
	assign o_bus_word = r_data;

	////////////////////////////////////////////////////////////
	// Bus FSM and channel valids
	////////////////////////////////////////////////////////////
	always_ff @(posedge S_AXI_ACLK)
	begin
		if (!S_AXI_ARESETN)
		begin
			state <= dcache_pkg::BUS_IDLE;
			M_AXI_AWVALID <= 1'b0;
			M_AXI_WVALID <= 1'b0;
			M_AXI_ARVALID <= 1'b0;
			line_err <= 1'b0;
			o_fill_beat <= 1'b0;
			o_fill_done <= 1'b0;
			o_fill_err <= 1'b0;
			o_bus_valid <= 1'b0;
			o_bus_err <= 1'b0;
			o_wr_done <= 1'b0;
		end
		else
		begin
			o_fill_beat <= 1'b0;
			o_fill_done <= 1'b0;
			o_fill_err <= 1'b0;
			o_bus_valid <= 1'b0;
			o_bus_err <= 1'b0;
			o_wr_done <= 1'b0;

			// AW and W drop independently
			if (M_AXI_AWREADY)
				M_AXI_AWVALID <= 1'b0;
			if (M_AXI_WREADY)
				M_AXI_WVALID <= 1'b0;
			if (M_AXI_ARREADY)
				M_AXI_ARVALID <= 1'b0;

			case (state)
			dcache_pkg::BUS_IDLE:
			begin
				line_err <= 1'b0;
				if (i_kind == dcache_pkg::REQ_WRITE)
				begin
					state <= dcache_pkg::BUS_WRITE;
					M_AXI_AWVALID <= 1'b1;
					M_AXI_WVALID <= 1'b1;
				end
				else if (i_kind == dcache_pkg::REQ_UREAD)
				begin
					state <= dcache_pkg::BUS_READ_SINGLE;
					M_AXI_ARVALID <= 1'b1;
				end
				else if (i_fill_req)
				begin
					state <= dcache_pkg::BUS_READ_LINE;
					M_AXI_ARVALID <= 1'b1;
				end
			end
			dcache_pkg::BUS_WRITE:
			begin
				if (M_AXI_BVALID)
				begin
					state <= dcache_pkg::BUS_IDLE;
					o_wr_done <= !b_err;
					o_bus_err <= b_err;
				end
			end
			dcache_pkg::BUS_READ_SINGLE:
			begin
				if (M_AXI_RVALID)
				begin
					state <= dcache_pkg::BUS_IDLE;
					o_bus_valid <= !r_err;
					o_bus_err <= r_err;
				end
			end
			dcache_pkg::BUS_READ_LINE:
			begin
				// Errors are gathered until the last beat
				if (M_AXI_RVALID)
				begin
					o_fill_beat <= 1'b1;
					if (r_err)
						line_err <= 1'b1;
					if (M_AXI_RLAST)
					begin
						state <= dcache_pkg::BUS_IDLE;
						o_fill_done <= !(line_err || r_err);
						o_fill_err <= line_err || r_err;
						o_bus_err <= line_err || r_err;
					end
				end
			end
			default:
				state <= dcache_pkg::BUS_IDLE;
			endcase
		end
	end

	////////////////////////////////////////////////////////////
	// Address and data payloads
	////////////////////////////////////////////////////////////
	always_ff @(posedge S_AXI_ACLK)
	begin
		if (state == dcache_pkg::BUS_IDLE)
		begin
			M_AXI_AWADDR <= i_addr;
			M_AXI_AWSIZE <= dcache_pkg::op_axsize(i_op);
			M_AXI_WDATA <= dcache_pkg::lane_data(i_op, i_data,
				i_addr[dcache_pkg::BYTE_LSB-1:0]);
			M_AXI_WSTRB <= dcache_pkg::lane_strb(i_op, i_addr[dcache_pkg::BYTE_LSB-1:0]);
			if (i_fill_req)
			begin
				M_AXI_ARADDR <= i_fill_addr;
				M_AXI_ARLEN <= 8'(dcache_pkg::LINE_ARLEN);
				M_AXI_ARSIZE <= 3'(dcache_pkg::BYTE_LSB);
			end
			else
			begin
				M_AXI_ARADDR <= i_addr;
				M_AXI_ARLEN <= 8'd0;
				M_AXI_ARSIZE <= dcache_pkg::op_axsize(i_op);
			end
		end
		if (M_AXI_RVALID)
			r_data <= M_AXI_RDATA;
	end

endmodule

`default_nettype wire

// File: dcache_response.sv
`timescale 1ns/10ps
`default_nettype none

module dcache_response (
	input	wire				S_AXI_ACLK,
	input	wire				S_AXI_ARESETN,
	input	wire				i_pipe_stb,
	input	wire dcache_pkg::req_kind_t	i_kind,
	input	wire dcache_pkg::mem_op_t	i_op,
	input	wire [dcache_pkg::BYTE_LSB-1:0]	i_addr,
	input	wire				i_hit_valid,
	input	wire [dcache_pkg::DATA_W-1:0]	i_hit_word,
	input	wire				i_bus_valid,
	input	wire [dcache_pkg::DATA_W-1:0]	i_bus_word,
	input	wire				i_bus_err,
	input	wire				i_wr_done,
	input	wire [dcache_pkg::NAUX-1:0]	i_wreg,
	output	logic				o_busy,
	output	logic				o_pipe_stalled,
	output	logic				o_valid,
	output	logic				o_err,
	output	logic [dcache_pkg::DATA_W-1:0]	o_data,
	output	logic [dcache_pkg::NAUX-1:0]	o_wreg
);

	logic				bad_q;
	logic				finish;
	logic	[dcache_pkg::DATA_W-1:0]	sel_word;

	// Any one of these ends the request
	assign finish = i_hit_valid || i_bus_valid || i_bus_err || i_wr_done || bad_q;

	// One request at a time, so stalled and busy coincide
	assign o_pipe_stalled = o_busy;

	assign sel_word = i_hit_valid ? i_hit_word : i_bus_word;

	always_ff @(posedge S_AXI_ACLK)
	begin
		if (!S_AXI_ARESETN)
		begin
			o_busy <= 1'b0;
			o_valid <= 1'b0;
			o_err <= 1'b0;
			bad_q <= 1'b0;
		end
		else
		begin
			// Misaligned error waits one more cycle
			bad_q <= (i_kind == dcache_pkg::REQ_BAD);
			o_valid <= i_hit_valid || i_bus_valid;
			o_err <= i_bus_err || bad_q;
			if (i_pipe_stb && !o_busy)
				o_busy <= 1'b1;
			else if (finish)
				o_busy <= 1'b0;
		end
	end

	////////////////////////////////////////////////////////////
	// Result word and register tag
	////////////////////////////////////////////////////////////
	always_ff @(posedge S_AXI_ACLK)
	begin
		if (i_hit_valid || i_bus_valid)
			o_data <= dcache_pkg::lane_extract(i_op, sel_word, i_addr);
		if (finish)
			o_wreg <= i_wreg;
	end

endmodule

`default_nettype wire

// File: axi_dcache.sv
`timescale 1ns/10ps
`default_nettype none

module axi_dcache (
	input	wire				S_AXI_ACLK,
	input	wire				S_AXI_ARESETN,
	input	wire				i_clear,
	// CPU side
	input	wire				i_pipe_stb,
	input	wire dcache_pkg::mem_op_t	i_op,
	input	wire [dcache_pkg::ADDR_W-1:0]	i_addr,
	input	wire [dcache_pkg::DATA_W-1:0]	i_data,
	input	wire [dcache_pkg::NAUX-1:0]	i_oreg,
	output	wire				o_busy,
	output	wire				o_pipe_stalled,
	output	wire				o_valid,
	output	wire				o_err,
	output	wire [dcache_pkg::NAUX-1:0]	o_wreg,
	output	wire [dcache_pkg::DATA_W-1:0]	o_data,
	// AXI4 master
	output	wire				M_AXI_AWVALID,
	input	wire				M_AXI_AWREADY,
	output	wire [dcache_pkg::ADDR_W-1:0]	M_AXI_AWADDR,
	output	wire [2:0]			M_AXI_AWSIZE,
	output	wire				M_AXI_WVALID,
	input	wire				M_AXI_WREADY,
	output	wire [dcache_pkg::DATA_W-1:0]	M_AXI_WDATA,
	output	wire [dcache_pkg::STRB_W-1:0]	M_AXI_WSTRB,
	input	wire				M_AXI_BVALID,
	input	wire [1:0]			M_AXI_BRESP,
	output	wire				M_AXI_ARVALID,
	input	wire				M_AXI_ARREADY,
	output	wire [dcache_pkg::ADDR_W-1:0]	M_AXI_ARADDR,
	output	wire [7:0]			M_AXI_ARLEN,
	output	wire [2:0]			M_AXI_ARSIZE,
	input	wire				M_AXI_RVALID,
	input	wire [dcache_pkg::DATA_W-1:0]	M_AXI_RDATA,
	input	wire				M_AXI_RLAST,
	input	wire [1:0]			M_AXI_RRESP
);

	dcache_pkg::req_kind_t			req_kind;
	dcache_pkg::mem_op_t			req_op;
	logic	[dcache_pkg::ADDR_W-1:0]	req_addr;
	logic	[dcache_pkg::DATA_W-1:0]	req_data;
	logic	[dcache_pkg::NAUX-1:0]		req_wreg;
	logic					hit_valid;
	logic	[dcache_pkg::DATA_W-1:0]	hit_word;
	logic					fill_req;
	logic	[dcache_pkg::ADDR_W-1:0]	fill_addr;
	logic					fill_beat;
	logic	[dcache_pkg::DATA_W-1:0]	fill_word;
	logic					fill_done;
	logic					fill_err;
	logic					bus_valid;
	logic	[dcache_pkg::DATA_W-1:0]	bus_word;
	logic					bus_err;
	logic					wr_done;

	dcache_request request_i (
		.S_AXI_ACLK,
		.S_AXI_ARESETN,
		.i_pipe_stb,
		.i_op,
		.i_addr,
		.i_data,
		.i_oreg,
		.i_busy(o_busy),
		.o_kind(req_kind),
		.o_op(req_op),
		.o_addr(req_addr),
		.o_data(req_data),
		.o_wreg(req_wreg)
	);

	dcache_lookup lookup_i (
		.S_AXI_ACLK,
		.S_AXI_ARESETN,
		.i_clear,
		.i_kind(req_kind),
		.i_op(req_op),
		.i_addr(req_addr),
		.i_data(req_data),
		.i_fill_beat(fill_beat),
		.i_fill_word(fill_word),
		.i_fill_done(fill_done),
		.i_fill_err(fill_err),
		.i_wr_done(wr_done),
		.o_hit_valid(hit_valid),
		.o_hit_word(hit_word),
		.o_fill_req(fill_req),
		.o_fill_addr(fill_addr)
	);

	dcache_bus_master bus_master_i (
		.S_AXI_ACLK,
		.S_AXI_ARESETN,
		.i_kind(req_kind),
		.i_op(req_op),
		.i_addr(req_addr),
		.i_data(req_data),
		.i_fill_req(fill_req),
		.i_fill_addr(fill_addr),
		.M_AXI_AWREADY,
		.M_AXI_WREADY,
		.M_AXI_BVALID,
		.M_AXI_BRESP,
		.M_AXI_ARREADY,
		.M_AXI_RVALID,
		.M_AXI_RDATA,
		.M_AXI_RLAST,
		.M_AXI_RRESP,
		.M_AXI_AWVALID,
		.M_AXI_AWADDR,
		.M_AXI_AWSIZE,
		.M_AXI_WVALID,
		.M_AXI_WDATA,
		.M_AXI_WSTRB,
		.M_AXI_ARVALID,
		.M_AXI_ARADDR,
		.M_AXI_ARLEN,
		.M_AXI_ARSIZE,
		.o_fill_beat(fill_beat),
		.o_fill_word(fill_word),
		.o_fill_done(fill_done),
		.o_fill_err(fill_err),
		.o_bus_valid(bus_valid),
		.o_bus_word(bus_word),
		.o_bus_err(bus_err),
		.o_wr_done(wr_done)
	);

	dcache_response response_i (
		.S_AXI_ACLK,
		.S_AXI_ARESETN,
		.i_pipe_stb,
		.i_kind(req_kind),
		.i_op(req_op),
		.i_addr(req_addr[dcache_pkg::BYTE_LSB-1:0]),
		.i_hit_valid(hit_valid),
		.i_hit_word(hit_word),
		.i_bus_valid(bus_valid),
		.i_bus_word(bus_word),
		.i_bus_err(bus_err),
		.i_wr_done(wr_done),
		.i_wreg(req_wreg),
		.o_busy,
		.o_pipe_stalled,
		.o_valid,
		.o_err,
		.o_data,
		.o_wreg
	);

endmodule

`default_nettype wire

// File: tb_axi_memory.sv
`timescale 1ns/10ps
`default_nettype none

module tb_axi_memory #(
	parameter logic [31:0] SEED = 32'h1
) (
	input	wire		S_AXI_ACLK,
	input	wire		S_AXI_ARESETN,
	input	wire		i_awvalid,
	output	logic		o_awready,
	input	wire [31:0]	i_awaddr,
	input	wire		i_wvalid,
	output	logic		o_wready,
	input	wire [31:0]	i_wdata,
	input	wire [3:0]	i_wstrb,
	output	logic		o_bvalid,
	output	logic [1:0]	o_bresp,
	input	wire		i_arvalid,
	output	logic		o_arready,
	input	wire [31:0]	i_araddr,
	input	wire [7:0]	i_arlen,
	output	logic		o_rvalid,
	output	logic [31:0]	o_rdata,
	output	logic		o_rlast,
	output	logic [1:0]	o_rresp
);

	localparam int WR_SLOTS = 32;

	logic	[31:0]	wr_addr [0:WR_SLOTS-1];
	logic	[31:0]	wr_word [0:WR_SLOTS-1];
	int		wr_used = 0;
	logic	[31:0]	rnd = SEED;
	logic		rd_busy;
	logic	[31:0]	rd_addr;
	logic	[7:0]	rd_left;
	logic		aw_got;
	logic		w_got;
	logic	[31:0]	aw_addr;
	logic	[31:0]	w_data;
	logic	[3:0]	w_strb;

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] y;

		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	// Written words override the address pattern
	function automatic logic [31:0] read_word(input logic [31:0] a);
		logic [31:0] wa;
		logic [31:0] w;

		wa = {a[31:2], 2'b00};
		w = wa ^ 32'h5a5a_0000;
		for (int k = 0; k < wr_used; k++)
		begin
			if (wr_addr[k] == wa)
				w = wr_word[k];
		end
		return w;
	endfunction

	task automatic write_word(input logic [31:0] a, input logic [31:0] d, input logic [3:0] s);
		logic [31:0] w;

		w = read_word(a);
		for (int k = 0; k < 4; k++)
		begin
			if (s[k])
				w[8*k +: 8] = d[8*k +: 8];
		end
		wr_addr[wr_used] = {a[31:2], 2'b00};
		wr_word[wr_used] = w;
		wr_used = wr_used + 1;
	endtask

	always @(posedge S_AXI_ACLK)
	begin
		rnd = xorshift32(rnd);
		if (!S_AXI_ARESETN)
		begin
			o_awready <= 1'b0;
			o_wready <= 1'b0;
			o_bvalid <= 1'b0;
			o_arready <= 1'b0;
			o_rvalid <= 1'b0;
			o_rlast <= 1'b0;
			rd_busy <= 1'b0;
			aw_got <= 1'b0;
			w_got <= 1'b0;
		end
		else
		begin
			//////////////////////////////////////////////////////////
			// Read channel
			//////////////////////////////////////////////////////////
			o_arready <= !rd_busy && rnd[0];
			if (i_arvalid && o_arready)
			begin
				rd_busy <= 1'b1;
				rd_addr <= {i_araddr[31:2], 2'b00};
				rd_left <= i_arlen;
			end
			o_rvalid <= 1'b0;
			if (rd_busy && rnd[1])
			begin
				o_rvalid <= 1'b1;
				o_rdata <= read_word(rd_addr);
				// Bit 30 marks the error region
				o_rresp <= rd_addr[30] ? 2'b10 : 2'b00;
				o_rlast <= (rd_left == 0);
				if (rd_left == 0)
					rd_busy <= 1'b0;
				rd_left <= rd_left - 1'b1;
				rd_addr <= rd_addr + 32'd4;
			end

			//////////////////////////////////////////////////////////
			// Write channels
			//////////////////////////////////////////////////////////
			o_awready <= !aw_got && rnd[2];
			o_wready <= !w_got && rnd[3];
			if (i_awvalid && o_awready)
			begin
				aw_got <= 1'b1;
				aw_addr <= i_awaddr;
			end
			if (i_wvalid && o_wready)
			begin
				w_got <= 1'b1;
				w_data <= i_wdata;
				w_strb <= i_wstrb;
			end
			o_bvalid <= 1'b0;
			if (aw_got && w_got)
			begin
				if (!aw_addr[30])
					write_word(aw_addr, w_data, w_strb);
				o_bvalid <= 1'b1;
				o_bresp <= aw_addr[30] ? 2'b10 : 2'b00;
				aw_got <= 1'b0;
				w_got <= 1'b0;
			end
		end
	end

endmodule

`default_nettype wire

// File: tb_axi_dcache.sv
`timescale 1ns/10ps
`default_nettype none

module tb_axi_dcache;

	localparam int PERIOD = 100;
	localparam logic [31:0] SEED = 32'h3b55bdec;
	localparam int N_REQ = 15;

	logic		clk = 1'b0;
	logic		rstn = 1'b0;
	logic		clear = 1'b0;
	logic		stb = 1'b0;
	dcache_pkg::mem_op_t	op = dcache_pkg::OP_LW;
	logic	[31:0]	addr = '0;
	logic	[31:0]	data = '0;
	logic	[4:0]	oreg = '0;
	wire		busy, stalled, valid, err;
	wire	[4:0]	wreg;
	wire	[31:0]	rdata;
	wire		awvalid, awready, wvalid, wready, bvalid, arvalid, arready;
	wire		rvalid, rlast;
	wire	[31:0]	awaddr, wdata, araddr, m_rdata;
	wire	[2:0]	awsize, arsize;
	wire	[3:0]	wstrb;
	wire	[7:0]	arlen;
	wire	[1:0]	bresp, rresp;

	int		errors = 0;
	int		proto_errors = 0;
	int		ar_count = 0;
	int		aw_count = 0;
	int		valid_count = 0;
	logic	[31:0]	ar_addr_q, w_data_q;
	logic	[31:0]	aw_addr_q;
	logic	[7:0]	ar_len_q;
	logic	[2:0]	ar_size_q;
	logic	[2:0]	aw_size_q;
	logic	[3:0]	w_strb_q;
	logic		prev_ar = 1'b0;
	logic		prev_aw = 1'b0;
	logic		prev_w = 1'b0;
	logic		res_valid, res_err;
	logic	[31:0]	res_data;
	logic	[4:0]	res_wreg;
	int		res_lat, res_errcycles;

	always #(PERIOD/2) clk = ~clk;

	axi_dcache dut_i (
		.S_AXI_ACLK(clk), .S_AXI_ARESETN(rstn), .i_clear(clear),
		.i_pipe_stb(stb), .i_op(op), .i_addr(addr), .i_data(data), .i_oreg(oreg),
		.o_busy(busy), .o_pipe_stalled(stalled), .o_valid(valid), .o_err(err),
		.o_wreg(wreg), .o_data(rdata),
		.M_AXI_AWVALID(awvalid), .M_AXI_AWREADY(awready), .M_AXI_AWADDR(awaddr),
		.M_AXI_AWSIZE(awsize), .M_AXI_WVALID(wvalid), .M_AXI_WREADY(wready),
		.M_AXI_WDATA(wdata), .M_AXI_WSTRB(wstrb), .M_AXI_BVALID(bvalid),
		.M_AXI_BRESP(bresp), .M_AXI_ARVALID(arvalid), .M_AXI_ARREADY(arready),
		.M_AXI_ARADDR(araddr), .M_AXI_ARLEN(arlen), .M_AXI_ARSIZE(arsize),
		.M_AXI_RVALID(rvalid), .M_AXI_RDATA(m_rdata), .M_AXI_RLAST(rlast),
		.M_AXI_RRESP(rresp)
	);

	tb_axi_memory #(.SEED(SEED)) memory_i (
		.S_AXI_ACLK(clk), .S_AXI_ARESETN(rstn),
		.i_awvalid(awvalid), .o_awready(awready), .i_awaddr(awaddr),
		.i_wvalid(wvalid), .o_wready(wready), .i_wdata(wdata), .i_wstrb(wstrb),
		.o_bvalid(bvalid), .o_bresp(bresp),
		.i_arvalid(arvalid), .o_arready(arready), .i_araddr(araddr), .i_arlen(arlen),
		.o_rvalid(rvalid), .o_rdata(m_rdata), .o_rlast(rlast), .o_rresp(rresp)
	);

	////////////////////////////////////////////////////////////
	// Expected values from the memory pattern
	////////////////////////////////////////////////////////////
	function automatic logic [31:0] model_word(input logic [31:0] a);
		return {a[31:2], 2'b00} ^ 32'h5a5a_0000;
	endfunction

	function automatic logic [31:0] narrow(input int nbytes, input logic [31:0] w,
			input logic [1:0] off);
		logic [31:0] s;

		s = w >> (8 * off);
		if (nbytes == 1)
			return s & 32'h0000_00ff;
		else if (nbytes == 2)
			return s & 32'h0000_ffff;
		return s;
	endfunction

	task automatic check_value(input string name, input logic [31:0] exp,
			input logic [31:0] act);
		assert (exp === act)
		else
		begin
			errors++;
			$display("** Error %s: expected %h, actual %h", name, exp, act);
		end
	endtask

	////////////////////////////////////////////////////////////
	// Bus monitor and protocol checks
	////////////////////////////////////////////////////////////
	always @(negedge clk)
	begin
		if (rstn)
		begin
			if (arvalid || awvalid || wvalid)
				valid_count++;
			if (arvalid && arready)
			begin
				ar_count++;
				ar_addr_q = araddr;
				ar_len_q = arlen;
				ar_size_q = arsize;
			end
			if (awvalid && awready)
			begin
				aw_count++;
				aw_addr_q = awaddr;
				aw_size_q = awsize;
			end
			if (wvalid && wready)
			begin
				w_data_q = wdata;
				w_strb_q = wstrb;
			end
			// A VALID must hold until its READY
			assert (!prev_ar || arvalid)
			else
			begin
				proto_errors++;
				$display("ARVALID dropped before ARREADY");
			end
			assert (!prev_aw || awvalid)
			else
			begin
				proto_errors++;
				$display("AWVALID dropped before AWREADY");
			end
			assert (!prev_w || wvalid)
			else
			begin
				proto_errors++;
				$display("WVALID dropped before WREADY");
			end
			assert (!(valid && err))
			else
			begin
				proto_errors++;
				$display("o_valid and o_err were high together");
			end
			// Pipe stalls exactly while a request is in flight
			assert (stalled === busy)
			else
			begin
				proto_errors++;
				$display("** Error pipe stall: expected %b, actual %b", busy, stalled);
			end
			prev_ar = arvalid && !arready;
			prev_aw = awvalid && !awready;
			prev_w = wvalid && !wready;
		end
	end

	////////////////////////////////////////////////////////////
	// Request driver
	////////////////////////////////////////////////////////////
	task automatic run_request(input dcache_pkg::mem_op_t r_op, input logic [31:0] r_addr,
			input logic [31:0] r_data, input logic [4:0] r_oreg);
		int n;

		n = 0;
		res_valid = 1'b0;
		res_err = 1'b0;
		res_errcycles = 0;
		res_lat = 0;
		@(posedge clk);
		#10;
		stb = 1'b1;
		op = r_op;
		addr = r_addr;
		data = r_data;
		oreg = r_oreg;
		// Acceptance edge
		@(posedge clk);
		#10;
		stb = 1'b0;
		do
		begin
			@(posedge clk);
			#1;
			n++;
			if (valid)
			begin
				res_valid = 1'b1;
				res_data = rdata;
				res_wreg = wreg;
				res_lat = n;
			end
			if (err)
				res_errcycles++;
		end
		while (busy);
		res_err = (res_errcycles != 0);
		@(posedge clk);
		#1;
		if (err)
			res_errcycles++;
	endtask

	task automatic check_load(input string name, input dcache_pkg::mem_op_t r_op,
			input logic [31:0] r_addr, input logic [31:0] exp, input int exp_ars,
			input logic [4:0] r_oreg);
		int ars;

		ars = ar_count;
		run_request(r_op, r_addr, 32'h0, r_oreg);
		check_value({name, " valid"}, 1, res_valid);
		check_value({name, " data"}, exp, res_data);
		check_value({name, " wreg"}, r_oreg, res_wreg);
		check_value({name, " AR count"}, exp_ars, ar_count - ars);
	endtask

	task automatic check_store(input string name, input dcache_pkg::mem_op_t r_op,
			input logic [31:0] r_addr, input logic [31:0] d, input logic [31:0] exp_wdata,
			input logic [3:0] exp_strb, input logic [2:0] exp_size);
		int aws;

		aws = aw_count;
		run_request(r_op, r_addr, d, 5'd0);
		check_value({name, " AW count"}, 1, aw_count - aws);
		check_value({name, " AWADDR"}, r_addr, aw_addr_q);
		check_value({name, " AWSIZE"}, exp_size, aw_size_q);
		check_value({name, " WDATA"}, exp_wdata, w_data_q);
		check_value({name, " WSTRB"}, exp_strb, w_strb_q);
		check_value({name, " err"}, 0, res_err);
	endtask

	task automatic check_misaligned(input string name, input dcache_pkg::mem_op_t r_op,
			input logic [31:0] r_addr);
		int vals;

		vals = valid_count;
		run_request(r_op, r_addr, 32'h1234_5678, 5'd0);
		check_value({name, " err cycles"}, 1, res_errcycles);
		check_value({name, " AXI valids"}, 0, valid_count - vals);
		check_value({name, " valid"}, 0, res_valid);
	endtask

	task automatic check_bus_error(input string name, input dcache_pkg::mem_op_t r_op,
			input logic [31:0] r_addr, input int exp_ars);
		int ars;

		ars = ar_count;
		run_request(r_op, r_addr, 32'h0, 5'd0);
		check_value({name, " err"}, 1, res_err);
		check_value({name, " valid"}, 0, res_valid);
		check_value({name, " AR count"}, exp_ars, ar_count - ars);
	endtask

	initial
	begin
		#(N_REQ * 200 * PERIOD);
		$display("Watchdog expired before the requests finished");
		$display("SOME TESTS FAILED");
		$finish;
	end

	initial
	begin
		repeat (4) @(posedge clk);
		#10;
		rstn = 1'b1;
		#1;
		check_value("reset outputs", 0, {busy, valid, err, arvalid, awvalid, wvalid});

		// Uncached loads
		check_load("uncached LB", dcache_pkg::OP_LB, 32'h8000_0105,
			narrow(1, model_word(32'h8000_0105), 2'd1), 1, 5'd1);
		check_value("uncached LB ARLEN", 0, ar_len_q);
		check_value("uncached LB ARSIZE", 0, ar_size_q);
		check_load("uncached LH", dcache_pkg::OP_LH, 32'h8000_0202,
			narrow(2, model_word(32'h8000_0202), 2'd2), 1, 5'd2);
		check_value("uncached LH ARLEN", 0, ar_len_q);
		check_value("uncached LH ARSIZE", 1, ar_size_q);
		check_load("uncached LW", dcache_pkg::OP_LW, 32'h8000_0300,
			model_word(32'h8000_0300), 1, 5'd3);
		check_value("uncached LW ARLEN", 0, ar_len_q);
		check_value("uncached LW ARSIZE", 2, ar_size_q);

		// Line fill, then a hit in the same line
		check_load("miss LW", dcache_pkg::OP_LW, 32'h0000_1008,
			model_word(32'h0000_1008), 1, 5'd4);
		check_value("miss ARLEN", 7, ar_len_q);
		check_value("miss ARSIZE", 2, ar_size_q);
		check_value("miss ARADDR", 32'h0000_1000, ar_addr_q);
		check_load("hit LW", dcache_pkg::OP_LW, 32'h0000_1014,
			model_word(32'h0000_1014), 0, 5'd5);
		check_value("hit latency", 3, res_lat);

		// Write-through to a present line and to an absent one
		check_store("SB present", dcache_pkg::OP_SB, 32'h0000_1011, 32'h0000_00a5,
			32'h0000_a500, 4'b0010, 3'd0);
		check_load("merged hit", dcache_pkg::OP_LW, 32'h0000_1010,
			(model_word(32'h0000_1010) & 32'hffff_00ff) | 32'h0000_a500, 0, 5'd6);
		check_store("SH absent", dcache_pkg::OP_SH, 32'h0000_2042, 32'h0000_beef,
			32'hbeef_0000, 4'b1100, 3'd1);
		check_load("merged fill", dcache_pkg::OP_LW, 32'h0000_2040,
			(model_word(32'h0000_2040) & 32'h0000_ffff) | 32'hbeef_0000, 1, 5'd7);

		check_misaligned("misaligned LW", dcache_pkg::OP_LW, 32'h0000_1002);
		check_misaligned("misaligned SH", dcache_pkg::OP_SH, 32'h0000_1003);

		// Error region
		check_bus_error("error uncached", dcache_pkg::OP_LW, 32'hc000_0010, 1);
		check_bus_error("error fill", dcache_pkg::OP_LW, 32'h4000_0020, 1);
		check_bus_error("error refill", dcache_pkg::OP_LW, 32'h4000_0020, 1);

		// Invalidate everything, the line must be fetched again
		@(posedge clk);
		#10;
		clear = 1'b1;
		@(posedge clk);
		#10;
		clear = 1'b0;
		check_load("after clear", dcache_pkg::OP_LW, 32'h0000_1010,
			(model_word(32'h0000_1010) & 32'hffff_00ff) | 32'h0000_a500, 1, 5'd8);

		$display("Checks failed: %0d, protocol errors: %0d", errors, proto_errors);
		if (errors == 0 && proto_errors == 0)
			$display("ALL TESTS PASSED");
		else
			$display("SOME TESTS FAILED");
		$finish;
	end

endmodule

`default_nettype wire

// File: sources.f
dcache_pkg.sv
dcache_request.sv
dcache_lookup.sv
dcache_bus_master.sv
dcache_response.sv
axi_dcache.sv
tb_axi_memory.sv
tb_axi_dcache.sv
